/* include/eth_tx_frame.svh */
`ifndef ETH_TX_FRAME_SVH
`define ETH_TX_FRAME_SVH

//--------------------------------------------------
// Fixed test frame, one MAC word per entry
//--------------------------------------------------
// Field order is data, be, eop, sop
// Only the first word carries sop and only the last carries eop
localparam tx_word_t FRAME_TABLE [FRAME_WORDS] = '{
	// Ethernet II header, dest MAC, source MAC, EtherType
	'{32'hFFFFFFFF, 2'd0, 1'b0, 1'b1},	// Broadcast dest, start of frame
	'{32'hFFFF04d4, 2'd0, 1'b0, 1'b0},
	'{32'hc4a5a8e1, 2'd0, 1'b0, 1'b0},
	'{32'h08004500, 2'd0, 1'b0, 1'b0},	// IPv4 type, version and IHL

	// IPv4 header
	'{32'h001e64d7, 2'd0, 1'b0, 1'b0},	// Total length, packet id
	'{32'h00008011, 2'd0, 1'b0, 1'b0},	// Flags, TTL, UDP protocol
	'{32'h0000c1e8, 2'd0, 1'b0, 1'b0},	// Checksum, source address
	'{32'h1a4fffff, 2'd0, 1'b0, 1'b0},
	'{32'hfffff718, 2'd0, 1'b0, 1'b0},	// Broadcast dest, source port

	// UDP header and payload
	'{32'h1388000a, 2'd0, 1'b0, 1'b0},	// Dest port, length
	'{32'he7cf3132, 2'd0, 1'b1, 1'b0}	// Checksum and "12", end of frame
};

`endif

/* src/eth_tx_pkg.sv */
package eth_tx_pkg;

	//--------------------------------------------------
	// Frame and timing constants
	//--------------------------------------------------
	localparam int FRAME_WORDS        = 11;	// Eth II + IPv4 + UDP test frame
	localparam int FRAME_IDX_W        = $clog2(FRAME_WORDS);
	localparam int START_DELAY_CYCLES = 64;	// Scaled down start timer
	localparam int START_CNT_W        = $clog2(START_DELAY_CYCLES + 1);
	localparam int IFG_CYCLES         = 12;	// Idle byte slots between frames
	localparam int GAP_CNT_W          = $clog2(IFG_CYCLES);

	// FIFO geometry
	localparam int FIFO_DEPTH   = 16;
	localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
	localparam int FIFO_LEVEL_W = FIFO_PTR_W + 1;	// Counts 0 up to FIFO_DEPTH

	//--------------------------------------------------
	// Shared types
	//--------------------------------------------------
	// MAC-side transmit word
	typedef struct packed {
		logic [31:0] data;	// MSB goes out first
		logic [1:0]  be;	// 0 means all four bytes valid
		logic        eop;
		logic        sop;
	} tx_word_t;

	// RGMII transmit pins, single rate
	typedef struct packed {
		logic [3:0] nib_rise;	// txd[3:0]
		logic [3:0] nib_fall;	// txd[7:4]
		logic       ctl;	// tx enable
	} rgmii_tx_t;

	// Serializer FSM
	typedef enum logic [1:0] {
		SER_IDLE,	// Waiting for a whole frame and MAC permission
		SER_BURST,	// One byte per cycle
		SER_GAP	// Inter-frame gap
	} ser_state_t;

	// Frame table needs tx_word_t and FRAME_WORDS above
	`include "eth_tx_frame.svh"

endpackage

/* src/eth_frame_source.sv */
`timescale 1ns/1ps

module eth_frame_source
	import eth_tx_pkg::*;
(
	input  logic     mac_tx_clk_o,	// Tx clock
	input  logic     rst_n,	// Async, active low
	input  logic     full_i,	// FIFO cannot take a word
	output logic     push_o,	// Write strobe into FIFO
	output tx_word_t push_word_o	// Word being written
);

	logic [START_CNT_W-1:0] delay_cnt;	// Start-up countdown
	logic                   delay_done;
	logic [FRAME_IDX_W-1:0] word_idx;	// Position in FRAME_TABLE
	logic                   last_word;

	//--------------------------------------------------
	// Start-up delay
	//--------------------------------------------------
	// Counts down once after reset and parks at zero
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
			delay_cnt <= START_CNT_W'(START_DELAY_CYCLES);
		else if (!delay_done)
			delay_cnt <= delay_cnt - 1'b1;
	end

	assign delay_done = (delay_cnt == '0);

	//--------------------------------------------------
	// Frame word pointer
	//--------------------------------------------------
	assign last_word = (word_idx == FRAME_IDX_W'(FRAME_WORDS - 1));

	// Moves only on an accepted push
	// Full FIFO freezes it, no word skipped
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
			word_idx <= '0;
		else if (push_o)
		begin
			if (last_word)
				word_idx <= '0;	// Wrap to next frame's sop word
			else
				word_idx <= word_idx + 1'b1;
		end
	end

	//--------------------------------------------------
	// Push side
	//--------------------------------------------------
	// Never pushes into a full FIFO
	assign push_o      = delay_done & ~full_i;
	assign push_word_o = FRAME_TABLE[word_idx];	// Table lookup, sop/eop flags included

endmodule

/* src/eth_tx_fifo.sv */
`timescale 1ns/1ps

module eth_tx_fifo
	import eth_tx_pkg::*;
(
	input  logic                    mac_tx_clk_o,
	input  logic                    rst_n,
	input  logic                    push_i,	// Write strobe
	input  tx_word_t                push_word_i,
	input  logic                    pop_i,	// Read strobe, one cycle
	output tx_word_t                pop_word_o,	// Head word, show-ahead
	output logic                    empty_o,
	output logic                    full_o,
	output logic [FIFO_LEVEL_W-1:0] level_o	// Words currently stored
);

	tx_word_t                mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]   wr_ptr;
	logic [FIFO_PTR_W-1:0]   rd_ptr;
	logic [FIFO_LEVEL_W-1:0] count;
	logic                    wr_en;	// Qualified push
	logic                    rd_en;	// Qualified pop

	assign wr_en = push_i & ~full_o;
	assign rd_en = pop_i & ~empty_o;

	//--------------------------------------------------
	// Storage
	//--------------------------------------------------
	always_ff @(posedge mac_tx_clk_o)
	begin
		if (wr_en)
			mem[wr_ptr] <= push_word_i;
	end

	// Head word straight from the array
	// New word shows one cycle after a push into an empty FIFO
	assign pop_word_o = mem[rd_ptr];

	//--------------------------------------------------
	// Pointers and occupancy
	//--------------------------------------------------
	// Depth is a power of two, pointers wrap by themselves
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Simultaneous push and pop leaves count unchanged
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else
		begin
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Status levels
	assign full_o  = (count == FIFO_LEVEL_W'(FIFO_DEPTH));
	assign empty_o = (count == '0);
	assign level_o = count;

endmodule

/* src/eth_gmii_serializer.sv */
`timescale 1ns/1ps

module eth_gmii_serializer
	import eth_tx_pkg::*;
(
	input  logic                    mac_tx_clk_o,
	input  logic                    rst_n,
	input  logic                    mac_tx_wa_i,	// MAC may take a new frame
	input  tx_word_t                pop_word_i,	// FIFO head word
	input  logic                    empty_i,
	input  logic [FIFO_LEVEL_W-1:0] level_i,	// FIFO fill count
	output logic                    pop_o,	// One-cycle read strobe
	output rgmii_tx_t               rgmii_tx_o
);

	ser_state_t           state;
	tx_word_t             cur_word;	// Word being serialized
	logic [1:0]           byte_idx;	// 0 is the MSB
	logic [GAP_CNT_W-1:0] gap_cnt;

	logic                 start;	// Frame launch this cycle
	tx_word_t             word_sel;
	logic [1:0]           idx_sel;
	logic [1:0]           last_idx;	// Last valid byte of word_sel
	logic                 last_byte;

	// GMII byte and its two register stages
	logic [7:0]           mac_txd;
	logic                 mac_txen;
	logic [7:0]           mac_txd_r;
	logic                 mac_txen_r;
	rgmii_tx_t            mac_txd_rr;	// Second stage, already split

	//--------------------------------------------------
	// Byte selection
	//--------------------------------------------------
	// Launch only with the whole frame buffered
	// so a burst never runs dry halfway
	assign start = (state == SER_IDLE) & mac_tx_wa_i & ~empty_i
		& (level_i >= FIFO_LEVEL_W'(FRAME_WORDS));

	// Byte 0 of the sop word goes out straight from the FIFO head
	assign word_sel = (state == SER_IDLE) ? pop_word_i : cur_word;
	assign idx_sel  = (state == SER_IDLE) ? 2'd0 : byte_idx;

	// be only shortens the eop word
	assign last_idx = (word_sel.eop && (word_sel.be != 2'd0)) ? word_sel.be - 2'd1 : 2'd3;

	assign mac_txen  = start | (state == SER_BURST);
	assign last_byte = mac_txen & (idx_sel == last_idx);

	// Sop word at launch, next word together with the last byte
	assign pop_o = start | ((state == SER_BURST) & last_byte & ~cur_word.eop);

	always_comb
	begin
		mac_txd = 8'h00;	// Idle byte
		if (mac_txen)
		begin
			case (idx_sel)
				2'd0:    mac_txd = word_sel.data[31:24];
				2'd1:    mac_txd = word_sel.data[23:16];
				2'd2:    mac_txd = word_sel.data[15:8];
				default: mac_txd = word_sel.data[7:0];
			endcase
		end
	end

	//--------------------------------------------------
	// FSM
	//--------------------------------------------------
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= SER_IDLE;
			byte_idx <= '0;
			gap_cnt  <= '0;
		end
		else
		begin
			case (state)
				SER_IDLE:
				begin
					if (start)
					begin
						byte_idx <= 2'd1;	// Byte 0 already sent
						if (last_byte & pop_word_i.eop)
						begin
							state   <= SER_GAP;	// One-byte frame
							gap_cnt <= GAP_CNT_W'(IFG_CYCLES - 1);
						end
						else
							state <= SER_BURST;
					end
				end
				SER_BURST:
				begin
					if (!last_byte)
						byte_idx <= byte_idx + 2'd1;
					else if (cur_word.eop)
					begin
						state   <= SER_GAP;
						gap_cnt <= GAP_CNT_W'(IFG_CYCLES - 1);
					end
					else
						byte_idx <= 2'd0;	// Fresh word loads this edge
				end
				SER_GAP:
				begin
					// IFG_CYCLES cycles in here
					if (gap_cnt == '0)
						state <= SER_IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default:
					state <= SER_IDLE;
			endcase
		end
	end

	// Current word follows every pop
	always_ff @(posedge mac_tx_clk_o)
	begin
		if (pop_o)
			cur_word <= pop_word_i;
	end

	//--------------------------------------------------
	// Output pipeline, two stages
	//--------------------------------------------------
	always_ff @(posedge mac_tx_clk_o)
	begin
		mac_txd_r <= mac_txd;
	end

	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
			mac_txen_r <= 1'b0;
		else
			mac_txen_r <= mac_txen;
	end

	// Low nibble on rising edge, high nibble on falling edge
	always_ff @(posedge mac_tx_clk_o or negedge rst_n)
	begin
		if (!rst_n)
			mac_txd_rr <= '0;
		else
		begin
			mac_txd_rr.nib_rise <= mac_txen_r ? mac_txd_r[3:0] : 4'h0;
			mac_txd_rr.nib_fall <= mac_txen_r ? mac_txd_r[7:4] : 4'h0;
			mac_txd_rr.ctl      <= mac_txen_r;
		end
	end

	assign rgmii_tx_o = mac_txd_rr;

endmodule

/* src/eth_tx_top.sv */
`timescale 1ns/1ps

module eth_tx_top
	import eth_tx_pkg::*;
(
	input  logic      mac_tx_clk_o,	// Single tx clock
	input  logic      rst_n,	// Async, active low
	input  logic      mac_tx_wa_i,	// MAC write allowed
	output rgmii_tx_t rgmii_tx_o	// RGMII nibbles and ctl
);

	//--------------------------------------------------
	// Producer to FIFO
	//--------------------------------------------------
	logic                    push;
	tx_word_t                push_word;
	logic                    full;

	//--------------------------------------------------
	// FIFO to serializer
	//--------------------------------------------------
	logic                    pop;
	tx_word_t                pop_word;
	logic                    empty;
	logic [FIFO_LEVEL_W-1:0] level;

	// Test frame generator
	eth_frame_source eth_frame_source_i (
		.mac_tx_clk_o (mac_tx_clk_o),
		.rst_n        (rst_n),
		.full_i       (full),
		.push_o       (push),
		.push_word_o  (push_word)
	);

	// Word buffer
	eth_tx_fifo eth_tx_fifo_i (
		.mac_tx_clk_o (mac_tx_clk_o),
		.rst_n        (rst_n),
		.push_i       (push),
		.push_word_i  (push_word),
		.pop_i        (pop),
		.pop_word_o   (pop_word),
		.empty_o      (empty),
		.full_o       (full),
		.level_o      (level)
	);

	// Word to GMII bytes to RGMII nibbles
	eth_gmii_serializer eth_gmii_serializer_i (
		.mac_tx_clk_o (mac_tx_clk_o),
		.rst_n        (rst_n),
		.mac_tx_wa_i  (mac_tx_wa_i),
		.pop_word_i   (pop_word),
		.empty_i      (empty),
		.level_i      (level),
		.pop_o        (pop),
		.rgmii_tx_o   (rgmii_tx_o)
	);

endmodule

/* dv/eth_tx_assertions.sv */
`timescale 1ns/1ps

module eth_tx_assertions
	import eth_tx_pkg::*;
(
	input logic      mac_tx_clk_o,
	input logic      rst_n,
	input logic      push_i,	// Producer write strobe
	input logic      full_i,
	input logic      pop_i,	// Serializer read strobe
	input logic      empty_i,
	input rgmii_tx_t rgmii_tx_i
);

	int unsigned assert_errs = 0;	// Failure tally

	//--------------------------------------------------
	// FIFO strobes
	//--------------------------------------------------
	a_push_not_full: assert property (@(posedge mac_tx_clk_o) disable iff (!rst_n)
		push_i |-> !full_i)
	else
	begin
		$error("push while FIFO full");
		assert_errs++;
	end

	a_pop_not_empty: assert property (@(posedge mac_tx_clk_o) disable iff (!rst_n)
		pop_i |-> !empty_i)
	else
	begin
		$error("pop while FIFO empty");
		assert_errs++;
	end

	// Idle wire carries zero nibbles
	a_idle_nibbles: assert property (@(posedge mac_tx_clk_o) disable iff (!rst_n)
		!rgmii_tx_i.ctl |-> ((rgmii_tx_i.nib_rise == 4'h0) && (rgmii_tx_i.nib_fall == 4'h0)))
	else
	begin
		$error("nonzero RGMII nibble while ctl low");
		assert_errs++;
	end

endmodule

bind eth_tx_top eth_tx_assertions eth_tx_assertions_i (
	.mac_tx_clk_o (mac_tx_clk_o),
	.rst_n        (rst_n),
	.push_i       (push),
	.full_i       (full),
	.pop_i        (pop),
	.empty_i      (empty),
	.rgmii_tx_i   (rgmii_tx_o)
);

/* dv/eth_tx_tb.sv */
`timescale 1ns/1ps

module eth_tx_tb
	import eth_tx_pkg::*;
();

	logic      mac_tx_clk_o = 1'b0;	// Starts low with no edge at time zero
	logic      rst_n;
	logic      mac_tx_wa_i;
	rgmii_tx_t rgmii_tx_o;

	logic [7:0] exp_bytes [4*FRAME_WORDS];	// Expected wire bytes of one frame
	int         exp_len;
	integer     seed;
	int         rnd;
	int         total;
	int         frames_mark;
	int         starts_mark;

	// Error tallies
	int byte_errs    = 0;
	int count_errs   = 0;
	int idle_errs    = 0;
	int gap_errs     = 0;
	int perm_errs    = 0;
	int timeout_errs = 0;

	// Monitor state
	logic in_frame      = 1'b0;
	logic wa_d1         = 1'b0;	// mac_tx_wa_i one cycle back
	logic wa_d2         = 1'b0;	// Two cycles back
	int   byte_cnt      = 0;
	int   gap_len       = 0;
	int   frames_done   = 0;
	int   frame_starts  = 0;
	int   cyc_after_rst = 0;

	eth_tx_top eth_tx_top_i (
		.mac_tx_clk_o (mac_tx_clk_o),
		.rst_n        (rst_n),
		.mac_tx_wa_i  (mac_tx_wa_i),
		.rgmii_tx_o   (rgmii_tx_o)
	);

	initial
	begin
		forever #4 mac_tx_clk_o = ~mac_tx_clk_o;	// 8 ns period
	end

	//--------------------------------------------------
	// Reference model
	//--------------------------------------------------
	// Frame length from the be code of the eop word
	function automatic int ref_len();
		int len;
		len = 0;
		for (int w = 0; w < FRAME_WORDS; w++)
		begin
			if (FRAME_TABLE[w].eop && (FRAME_TABLE[w].be != 2'd0))
				len += FRAME_TABLE[w].be;
			else
				len += 4;
		end
		return len;
	endfunction

	// Byte n on the wire with the MSB of each word first
	function automatic logic [7:0] ref_byte(input int n);
		tx_word_t w;
		int       pos;
		w   = FRAME_TABLE[n / 4];
		pos = n % 4;
		return w.data[31 - 8*pos -: 8];
	endfunction

	//--------------------------------------------------
	// Compare tasks
	//--------------------------------------------------
	task automatic check_byte(input logic [7:0] exp, input rgmii_tx_t sample, input int idx);
		logic [7:0] got;
		got = {sample.nib_fall, sample.nib_rise};	// Falling nibble is the high half
		if (got !== exp)
		begin
			byte_errs++;
			$display("ERROR rgmii_tx_o byte %0d: expected %h, got %h", idx, exp, got);
		end
	endtask

	task automatic check_count(input int len);
		if (len != exp_len)
		begin
			count_errs++;
			$display("ERROR rgmii_tx_o.ctl run length: expected %h, got %h", exp_len, len);
		end
	endtask

	task automatic check_idle(input rgmii_tx_t sample);
		if (sample !== '0)
		begin
			idle_errs++;
			$display("ERROR rgmii_tx_o at start-up: expected %h, got %h", 9'h000, sample);
		end
	endtask

	//--------------------------------------------------
	// Bounded waits
	//--------------------------------------------------
	task automatic wait_frames(input int target, input int max_cycles);
		int cyc;
		cyc = 0;
		while ((frames_done < target) && (cyc < max_cycles))
		begin
			@(posedge mac_tx_clk_o);
			cyc++;
		end
		if (frames_done < target)
		begin
			timeout_errs++;
			$display("Timeout: only %0d of %0d frames finished", frames_done, target);
		end
	endtask

	task automatic wait_frame_end(input int max_cycles);
		int cyc;
		cyc = 0;
		while (in_frame && (cyc < max_cycles))
		begin
			@(posedge mac_tx_clk_o);
			cyc++;
		end
		if (in_frame)
		begin
			timeout_errs++;
			$display("Timeout: frame on the wire never ended");
		end
	endtask

	//--------------------------------------------------
	// Monitor and compare process
	//--------------------------------------------------
	// Sampled mid-cycle away from the driving edge
	always @(negedge mac_tx_clk_o)
	begin
		if (!rst_n)
		begin
			cyc_after_rst = 0;
			check_idle(rgmii_tx_o);	// Quiet through reset
		end
		else
		begin
			if (cyc_after_rst < START_DELAY_CYCLES)
			begin
				cyc_after_rst++;
				check_idle(rgmii_tx_o);
			end
			if (rgmii_tx_o.ctl)
			begin
				if (!in_frame)
				begin
					in_frame = 1'b1;	// ctl rising edge
					byte_cnt = 0;
					frame_starts++;
					if (!wa_d2)
					begin
						perm_errs++;
						$display("Frame started although mac_tx_wa_i was low at launch");
					end
					if ((frames_done > 0) && (gap_len < IFG_CYCLES))
					begin
						gap_errs++;
						$display("Gap of only %0d idle cycles before frame %0d", gap_len,
							frame_starts);
					end
				end
				if (byte_cnt < exp_len)
					check_byte(exp_bytes[byte_cnt], rgmii_tx_o, byte_cnt);
				byte_cnt++;
			end
			else
			begin
				if (in_frame)
				begin
					in_frame = 1'b0;	// ctl falling edge closes the frame
					check_count(byte_cnt);
					frames_done++;
					gap_len = 0;
				end
				gap_len++;
			end
		end
		// Permission history for the launch check
		wa_d2 = wa_d1;
		wa_d1 = mac_tx_wa_i;
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------
	initial
	begin
		seed = 8;
		rst_n       <= 1'b0;
		mac_tx_wa_i <= 1'b1;
		exp_len = ref_len();
		for (int i = 0; i < exp_len; i++)
			exp_bytes[i] = ref_byte(i);

		repeat (3) @(posedge mac_tx_clk_o);
		rst_n <= 1'b1;

		// Permission held high for eight back-to-back frames
		wait_frames(8, 2000);

		// Permission held low
		@(posedge mac_tx_clk_o);
		mac_tx_wa_i <= 1'b0;
		repeat (4) @(posedge mac_tx_clk_o);	// Launch already decided still shows up
		wait_frame_end(200);
		starts_mark = frame_starts;
		repeat (300) @(posedge mac_tx_clk_o);
		if (frame_starts != starts_mark)
		begin
			perm_errs++;
			$display("Frame started while mac_tx_wa_i was held low");
		end

		// Random permission
		frames_mark = frames_done;
		repeat (1500)
		begin
			@(posedge mac_tx_clk_o);
			rnd = $random(seed);
			mac_tx_wa_i <= rnd[0];
		end
		@(posedge mac_tx_clk_o);
		mac_tx_wa_i <= 1'b0;
		repeat (4) @(posedge mac_tx_clk_o);
		wait_frame_end(200);
		if (frames_done == frames_mark)
		begin
			perm_errs++;
			$display("No frame completed while mac_tx_wa_i toggled randomly");
		end

		total = byte_errs + count_errs + idle_errs + gap_errs + perm_errs + timeout_errs
			+ eth_tx_top_i.eth_tx_assertions_i.assert_errs;
		$display(
			"Errors: byte %0d, len %0d, idle %0d, gap %0d, perm %0d, timeout %0d, assert %0d",
			byte_errs, count_errs, idle_errs, gap_errs, perm_errs, timeout_errs,
			eth_tx_top_i.eth_tx_assertions_i.assert_errs);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+include
src/eth_tx_pkg.sv
src/eth_frame_source.sv
src/eth_tx_fifo.sv
src/eth_gmii_serializer.sv
src/eth_tx_top.sv
dv/eth_tx_assertions.sv
dv/eth_tx_tb.sv
